// File: include/cart_loader_cfg.svh
// Index codes, memory layout and title table size are fixed; the title table itself lives in the package
`ifndef CART_LOADER_CFG_SVH
`define CART_LOADER_CFG_SVH

// ==========================================================
// Host index codes
// ==========================================================
`define CL_INDEX_BIOS     8'd0        // Boot ROM image
`define CL_INDEX_CHEAT    8'd255      // Cheat record list
// Every other index is a cartridge, top two bits give its type

// ==========================================================
// Cartridge layout
// ==========================================================
`define CL_ROM_BYTE_BASE  27'd786432  // Game ROM offset in external memory
`define CL_HEADER_LINE    23'd10      // Addr bits 26:4 of the line with the title
`define CL_ID_BYTES       12          // Title length in bytes

// Tag that marks a 1 Mbit flash save type, 9 characters
`define CL_FLASH_TAG      "FLASH1M_V"

// Entries in the title quirk table
`define CL_QUIRK_COUNT    3

`endif

// File: logic/cart_loader_pkg.sv
// Title table entries are exactly CL_ID_BYTES characters; shorter titles must be padded with zeros
`include "cart_loader_cfg.svh"

package cart_loader_pkg;

	// ==========================================================
	// Host side
	// ==========================================================
	typedef logic [26:0]  host_addr_t;    // Byte address from host
	typedef logic [15:0]  host_word_t;    // One host data word
	typedef logic [7:0]   host_index_t;   // What the image is

	// ==========================================================
	// Consumer side
	// ==========================================================
	typedef logic [11:0]  bios_addr_t;    // Boot ROM 32-bit word address
	typedef logic [31:0]  bios_word_t;
	typedef logic [127:0] cheat_code_t;   // Flags, address, compare, replace
	typedef logic [25:0]  rom_addr_t;     // External memory, 16-bit units
	typedef logic [24:0]  pak_addr_t;     // Pak 32-bit word address
	typedef logic [1:0]   cart_type_t;    // Index bits 7:6
	typedef logic [8*`CL_ID_BYTES-1:0] cart_id_t;

	// Kind of download in progress
	typedef enum logic [1:0] {
		DL_NONE,
		DL_BIOS,
		DL_CART,
		DL_CHEAT
	} dl_kind_e;

	// ==========================================================
	// Title quirk table
	// ==========================================================
	localparam cart_id_t quirk_ids [0:`CL_QUIRK_COUNT-1] = '{
		"TESTCART0001",
		"TESTCART0002",
		"TESTCART0003"
	};

	// Bit i belongs to entry i
	localparam logic [`CL_QUIRK_COUNT-1:0] quirk_sram  = 3'b011;
	localparam logic [`CL_QUIRK_COUNT-1:0] quirk_remap = 3'b110;

endpackage

// File: logic/download_if.sv
// Single clock domain; all members change only on clk_sys and come from one decoder
`timescale 1ns/1ps

interface download_if;
	import cart_loader_pkg::*;

	dl_kind_e    kind;     // Level, held for the whole download
	logic        start;    // First cycle of a download
	logic        finish;   // First cycle back at DL_NONE
	host_addr_t  addr;     // Host byte address, registered
	host_word_t  data;     // Host word, registered
	logic        wr;       // Host write strobe, registered

	// Decoder side
	modport source (
		output kind,
		output start,
		output finish,
		output addr,
		output data,
		output wr
	);

	// Consumers
	modport sink (
		input  kind,
		input  start,
		input  finish,
		input  addr,
		input  data,
		input  wr
	);

endinterface

// File: logic/download_decoder.sv
// ioctl_index must stay stable while ioctl_download is high; every output lags the host by one cycle
`timescale 1ns/1ps
`include "cart_loader_cfg.svh"

module download_decoder (
	input  logic                         clk_sys,
	input  logic                         reset,
	input  logic                         ioctl_download,
	input  cart_loader_pkg::host_index_t ioctl_index,
	input  cart_loader_pkg::host_addr_t  ioctl_addr,
	input  cart_loader_pkg::host_word_t  ioctl_dout,
	input  logic                         ioctl_wr,
	download_if.source                   dl
);
	import cart_loader_pkg::*;

	dl_kind_e kind_next;                // Kind seen on the host pins this cycle

	// Index to download kind
	always_comb begin
		if (!ioctl_download)
			kind_next = DL_NONE;
		else if (ioctl_index == `CL_INDEX_BIOS)
			kind_next = DL_BIOS;
		else if (ioctl_index == `CL_INDEX_CHEAT)
			kind_next = DL_CHEAT;
		else
			kind_next = DL_CART;        // Any other index is a game
	end

	// ==========================================================
	// Control, compared against the registered kind
	// ==========================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl.kind   <= DL_NONE;
			dl.start  <= 1'b0;
			dl.finish <= 1'b0;
			dl.wr     <= 1'b0;
		end else begin
			dl.kind   <= kind_next;
			dl.start  <= (kind_next != DL_NONE) && (dl.kind == DL_NONE);   // Rising edge
			dl.finish <= (kind_next == DL_NONE) && (dl.kind != DL_NONE);   // Lands with NONE
			dl.wr     <= ioctl_wr && ioctl_download;   // Stray strobes outside a download dropped
		end
	end

	// Payload, no reset
	always_ff @(posedge clk_sys) begin
		dl.addr <= ioctl_addr;
		dl.data <= ioctl_dout;
	end

endmodule

// File: logic/bios_word_packer.sv
// Host sends the low half-word first; a high half without a preceding low half writes stale low data
`timescale 1ns/1ps

module bios_word_packer (
	input  logic                        clk_sys,
	input  logic                        reset,
	download_if.sink                    dl,
	output cart_loader_pkg::bios_addr_t bios_wraddr,
	output cart_loader_pkg::bios_word_t bios_wrdata,
	output logic                        bios_wr
);
	import cart_loader_pkg::*;

	logic bios_wr_in;                   // Write strobe inside a boot ROM download
	logic high_half;                    // Address bit 1 picks the upper 16 bits

	assign bios_wr_in = dl.wr && (dl.kind == DL_BIOS);
	assign high_half  = dl.addr[1];

	// ==========================================================
	// Write pulse, once per completed 32-bit word
	// ==========================================================
	always_ff @(posedge clk_sys) begin
		if (reset)
			bios_wr <= 1'b0;
		else
			bios_wr <= bios_wr_in && high_half;
	end

	// Word assembly
	always_ff @(posedge clk_sys) begin
		if (bios_wr_in) begin
			if (!high_half) begin
				bios_wrdata[15:0] <= dl.data;            // Low half, wait for its partner
			end else begin
				bios_wrdata[31:16] <= dl.data;
				bios_wraddr        <= dl.addr[13:2];      // Byte address to word address
			end
		end
	end

endmodule

// File: logic/cheat_code_assembler.sv
// Each cheat record is 16 bytes sent in address order; the record is only complete at offset 14
`timescale 1ns/1ps

module cheat_code_assembler (
	input  logic                         clk_sys,
	input  logic                         reset,
	download_if.sink                     dl,
	output cart_loader_pkg::cheat_code_t cheat_code,
	output logic                         cheat_valid,
	output logic                         cheat_clear
);
	import cart_loader_pkg::*;

	logic cheat_wr;                     // Write inside a cheat download

	assign cheat_wr = dl.wr && (dl.kind == DL_CHEAT);

	// ==========================================================
	// Strobes
	// ==========================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cheat_clear <= 1'b0;
			cheat_valid <= 1'b0;
		end else begin
			cheat_clear <= dl.start && (dl.kind == DL_CHEAT);   // Drop the old list
			cheat_valid <= cheat_wr && (dl.addr[3:0] == 4'd14);  // Last word of the record
		end
	end

	// Record layout, top down
	//   127:96 flags  95:64 address  63:32 compare  31:0 replace
	// Lower word of each field arrives first
	always_ff @(posedge clk_sys) begin
		if (cheat_wr) begin
			case (dl.addr[3:0])
				4'd0:    cheat_code[111:96]  <= dl.data;
				4'd2:    cheat_code[127:112] <= dl.data;
				4'd4:    cheat_code[79:64]   <= dl.data;   // Target address
				4'd6:    cheat_code[95:80]   <= dl.data;
				4'd8:    cheat_code[47:32]   <= dl.data;   // Compare value
				4'd10:   cheat_code[63:48]   <= dl.data;
				4'd12:   cheat_code[15:0]    <= dl.data;   // Replace value
				4'd14:   cheat_code[31:16]   <= dl.data;
				default: ;                                 // Odd offsets never sent
			endcase
		end
	end

endmodule

// File: logic/cart_header_scan.sv
// Title must sit in header line CL_HEADER_LINE and the flash tag is only found inside one download
`timescale 1ns/1ps
`include "cart_loader_cfg.svh"

module cart_header_scan (
	input  logic                         clk_sys,
	input  logic                         reset,
	download_if.sink                     dl,
	input  cart_loader_pkg::host_index_t host_index,
	output cart_loader_pkg::cart_type_t  cart_type,
	output logic                         cart_loaded,
	output logic                         flash_1m,
	output cart_loader_pkg::pak_addr_t   max_pak_addr,
	output logic                         sram_quirk,
	output logic                         memory_remap_quirk
);
	import cart_loader_pkg::*;

	cart_id_t    title;                 // First title byte in the top byte
	logic [63:0] byte_hist;             // Last eight bytes, newest at the bottom
	host_addr_t  last_addr;             // Address of the latest cartridge write
	logic        in_cart;               // Cartridge download seen since last finish
	logic        cart_start;
	logic        cart_wr;
	logic        header_hit;            // Write lands in the title line
	logic [6:0]  title_pos;             // Bit position of a word within the title

	assign cart_start = dl.start && (dl.kind == DL_CART);
	assign cart_wr    = dl.wr && (dl.kind == DL_CART);
	assign header_hit = (dl.addr[26:4] == `CL_HEADER_LINE);
	assign title_pos  = {4'(`CL_ID_BYTES - 2) - dl.addr[3:0], 3'b000};

	// ==========================================================
	// Cartridge facts, cleared at each new cartridge
	// ==========================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_type          <= '0;
			cart_loaded        <= 1'b0;
			flash_1m           <= 1'b0;
			sram_quirk         <= 1'b0;
			memory_remap_quirk <= 1'b0;
			in_cart            <= 1'b0;
		end else begin
			if (cart_start) begin
				cart_type          <= host_index[7:6];
				cart_loaded        <= 1'b1;
				flash_1m           <= 1'b0;
				sram_quirk         <= 1'b0;
				memory_remap_quirk <= 1'b0;
				in_cart            <= 1'b1;
			end else if (dl.finish) begin
				in_cart <= 1'b0;
			end

			if (cart_wr) begin
				// Tag may end on either byte of the word
				if ({byte_hist, dl.data[7:0]} == `CL_FLASH_TAG)
					flash_1m <= 1'b1;
				if ({byte_hist[55:0], dl.data[7:0], dl.data[15:8]} == `CL_FLASH_TAG)
					flash_1m <= 1'b1;

				// Title complete once the word after it arrives
				if (header_hit && (dl.addr[3:0] == 4'(`CL_ID_BYTES))) begin
					for (int i = 0; i < `CL_QUIRK_COUNT; i++) begin
						if (title == quirk_ids[i]) begin
							sram_quirk         <= quirk_sram[i];
							memory_remap_quirk <= quirk_remap[i];
						end
					end
				end
			end
		end
	end

	// Byte history, title and size tracking
	always_ff @(posedge clk_sys) begin
		if (cart_start) begin
			byte_hist <= '0;
			title     <= '0;
		end
		if (cart_wr) begin
			byte_hist <= {byte_hist[47:0], dl.data[7:0], dl.data[15:8]};   // Low byte first
			last_addr <= dl.addr;
			if (header_hit && (dl.addr[3:0] < 4'(`CL_ID_BYTES)))
				title[title_pos +: 16] <= {dl.data[7:0], dl.data[15:8]};
		end
		if (dl.finish && in_cart)
			max_pak_addr <= last_addr[26:2];                             // Byte to 32-bit word
	end

endmodule

// File: logic/rom_write_port.sv
// One write in flight; the host must honour ioctl_wait, there is no queue behind the request
`timescale 1ns/1ps
`include "cart_loader_cfg.svh"

module rom_write_port (
	input  logic                        clk_sys,
	input  logic                        reset,
	download_if.sink                    dl,
	output logic                        rom_req,
	output cart_loader_pkg::rom_addr_t  rom_addr,
	output cart_loader_pkg::host_word_t rom_data,
	input  logic                        rom_ack,
	output logic                        ioctl_wait
);
	import cart_loader_pkg::*;

	logic       cart_wr;                // Cartridge word to store
	host_addr_t mem_byte_addr;          // Byte address in external memory

	assign cart_wr       = dl.wr && (dl.kind == DL_CART);
	assign mem_byte_addr = dl.addr + `CL_ROM_BYTE_BASE;

	// ==========================================================
	// Request strobe and host hold-off
	// ==========================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_req    <= 1'b0;
			ioctl_wait <= 1'b0;
		end else begin
			rom_req <= cart_wr;
			if (dl.kind != DL_CART) begin
				ioctl_wait <= 1'b0;     // Never hold the host outside a cartridge
			end else begin
				if (rom_ack)
					ioctl_wait <= 1'b0;  // Memory took the word
				if (cart_wr)
					ioctl_wait <= 1'b1;  // New word wins over an old ack
			end
		end
	end

	// Address and data ride with the strobe
	always_ff @(posedge clk_sys) begin
		if (cart_wr) begin
			rom_addr <= mem_byte_addr[26:1];   // 16-bit units
			rom_data <= dl.data;
		end
	end

endmodule

// File: logic/cart_loader.sv
// Single clock clk_sys; rom_ack must answer each rom_req once, and the host must obey ioctl_wait
`timescale 1ns/1ps

module cart_loader (
	input  logic                         clk_sys,
	input  logic                         reset,

	// Host download stream
	input  logic                         ioctl_download,
	input  cart_loader_pkg::host_index_t ioctl_index,
	input  cart_loader_pkg::host_addr_t  ioctl_addr,
	input  cart_loader_pkg::host_word_t  ioctl_dout,
	input  logic                         ioctl_wr,
	output logic                         ioctl_wait,

	// Boot ROM writes
	output cart_loader_pkg::bios_addr_t  bios_wraddr,
	output cart_loader_pkg::bios_word_t  bios_wrdata,
	output logic                         bios_wr,

	// Cheat records
	output cart_loader_pkg::cheat_code_t cheat_code,
	output logic                         cheat_valid,
	output logic                         cheat_clear,

	// External memory
	output logic                         rom_req,
	output cart_loader_pkg::rom_addr_t   rom_addr,
	output cart_loader_pkg::host_word_t  rom_data,
	input  logic                         rom_ack,

	// Cartridge facts
	output cart_loader_pkg::cart_type_t  cart_type,
	output logic                         cart_loaded,
	output logic                         flash_1m,
	output cart_loader_pkg::pak_addr_t   max_pak_addr,
	output logic                         sram_quirk,
	output logic                         memory_remap_quirk
);

	// ==========================================================
	// Decoded stream, one source and four sinks
	// ==========================================================
	download_if dl ();

	download_decoder u_decoder (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_wr       (ioctl_wr),
		.dl             (dl.source)
	);

	bios_word_packer u_bios (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl          (dl.sink),
		.bios_wraddr (bios_wraddr),
		.bios_wrdata (bios_wrdata),
		.bios_wr     (bios_wr)
	);

	cheat_code_assembler u_cheat (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl          (dl.sink),
		.cheat_code  (cheat_code),
		.cheat_valid (cheat_valid),
		.cheat_clear (cheat_clear)
	);

	// Index still stable at start, so the raw pins are enough for the type
	cart_header_scan u_scan (
		.clk_sys            (clk_sys),
		.reset              (reset),
		.dl                 (dl.sink),
		.host_index         (ioctl_index),
		.cart_type          (cart_type),
		.cart_loaded        (cart_loaded),
		.flash_1m           (flash_1m),
		.max_pak_addr       (max_pak_addr),
		.sram_quirk         (sram_quirk),
		.memory_remap_quirk (memory_remap_quirk)
	);

	rom_write_port u_rom (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dl         (dl.sink),
		.rom_req    (rom_req),
		.rom_addr   (rom_addr),
		.rom_data   (rom_data),
		.rom_ack    (rom_ack),
		.ioctl_wait (ioctl_wait)
	);

endmodule

// File: bench/tb_clock_gen.sv
// Free-running 4 ns clock from time zero; reset is held over the first two rising edges only
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk_sys,
	output logic reset
);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;   // 4 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (2) @(posedge clk_sys);
		reset <= 1'b0;                   // Released after the second edge
	end

endmodule

// File: bench/cart_loader_tb.sv
// Host and memory models obey the ioctl_wait and rom_ack rules; ack delay is 0 to 5 cycles
`timescale 1ns/1ps
`include "cart_loader_cfg.svh"

module cart_loader_tb;
	import cart_loader_pkg::*;

	localparam int BIOS_PAIRS      = 16;
	localparam int CHEAT_RECS      = 2;
	localparam int CART_WORDS      = 96 + 100 + 90 + 94;   // Sum over the four carts
	localparam int WORDS_SENT      = 2 * BIOS_PAIRS + 8 * CHEAT_RECS + CART_WORDS;
	localparam int CYCLES_PER_WORD = 16;                   // Write, wait rise, ack and slack
	localparam int CLK_PERIOD_NS   = 4;
	localparam int TIMEOUT_NS      = (WORDS_SENT * CYCLES_PER_WORD + 200) * CLK_PERIOD_NS;
	localparam int HEADER_BYTE     = 16 * `CL_HEADER_LINE;  // First title byte
	localparam logic [71:0] FLASH_TAG = `CL_FLASH_TAG;

	logic        clk_sys;
	logic        reset;
	logic        ioctl_download;
	host_index_t ioctl_index;
	host_addr_t  ioctl_addr;
	host_word_t  ioctl_dout;
	logic        ioctl_wr;
	logic        ioctl_wait;
	bios_addr_t  bios_wraddr;
	bios_word_t  bios_wrdata;
	logic        bios_wr;
	cheat_code_t cheat_code;
	logic        cheat_valid;
	logic        cheat_clear;
	logic        rom_req;
	rom_addr_t   rom_addr;
	host_word_t  rom_data;
	logic        rom_ack;
	cart_type_t  cart_type;
	logic        cart_loaded;
	logic        flash_1m;
	pak_addr_t   max_pak_addr;
	logic        sram_quirk;
	logic        memory_remap_quirk;

	// Expected values set by the stimulus before the event they belong to
	bios_word_t  exp_bios_data;
	bios_addr_t  exp_bios_addr;
	cheat_code_t exp_cheat;
	logic        exp_flash;
	logic        exp_sram;
	logic        exp_remap;
	pak_addr_t   exp_max;
	logic [7:0]  image [0:255];   // Cartridge bytes in address order

	tb_clock_gen u_clk (
		.clk_sys (clk_sys),
		.reset   (reset)
	);

	cart_loader u_dut (.*);

	// ==========================================================
	// Failure reporting
	// ==========================================================
	task automatic abort_run(input string what);
		$display("%s", what);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string what);
		abort_run($sformatf("** Error at %0t: %s", $time, what));
	endtask

	// Bit position of cheat half-word w with flags on top and the low half first
	function automatic int cheat_bit(input int w);
		int field;
		int half;
		field = w / 2;                 // 0 flags, 1 address, 2 compare, 3 replace
		half  = w % 2;
		return 96 - 32 * field + 16 * half;
	endfunction

	// Cartridge byte to external memory address in 16-bit units
	function automatic rom_addr_t expected_rom_addr(input host_addr_t byte_addr);
		logic [27:0] mem_byte;
		mem_byte = {1'b0, byte_addr} + 28'(`CL_ROM_BYTE_BASE);
		return rom_addr_t'(mem_byte >> 1);
	endfunction

	// ==========================================================
	// Host events seen at the pins
	// ==========================================================
	logic download_q;                  // ioctl_download one edge ago
	logic host_wr;
	logic cart_index;
	logic bios_high_wr;
	logic cheat_last_wr;
	logic cheat_rise;
	logic cart_wr;
	logic cart_rise;
	logic cart_fall;

	always @(posedge clk_sys) begin
		if (reset)
			download_q <= 1'b0;
		else
			download_q <= ioctl_download;
	end

	assign host_wr       = ioctl_download && ioctl_wr;
	assign cart_index    = (ioctl_index != `CL_INDEX_BIOS) && (ioctl_index != `CL_INDEX_CHEAT);
	assign bios_high_wr  = host_wr && (ioctl_index == `CL_INDEX_BIOS) && ioctl_addr[1];
	assign cheat_last_wr = host_wr && (ioctl_index == `CL_INDEX_CHEAT) && (ioctl_addr[3:0] == 4'd14);
	assign cheat_rise    = ioctl_download && !download_q && (ioctl_index == `CL_INDEX_CHEAT);
	assign cart_wr       = host_wr && cart_index;
	assign cart_rise     = ioctl_download && !download_q && cart_index;
	assign cart_fall     = !ioctl_download && download_q && cart_index;

	// ==========================================================
	// Checks sampled on the rising edge
	// ==========================================================
	bios_timing: assert property (@(posedge clk_sys) disable iff (reset)
		bios_wr == $past(bios_high_wr, 2))
		else report_mismatch("bios_wr not 2 cycles after a high half-word");
	bios_value: assert property (@(posedge clk_sys) disable iff (reset)
		bios_wr |-> (bios_wrdata == exp_bios_data) && (bios_wraddr == exp_bios_addr))
		else report_mismatch("bios word or address wrong");
	cheat_clear_timing: assert property (@(posedge clk_sys) disable iff (reset)
		cheat_clear == $past(cheat_rise, 2))
		else report_mismatch("cheat_clear not 2 cycles after cheat download start");
	cheat_valid_timing: assert property (@(posedge clk_sys) disable iff (reset)
		cheat_valid == $past(cheat_last_wr, 2))
		else report_mismatch("cheat_valid not 2 cycles after offset 14");
	cheat_value: assert property (@(posedge clk_sys) disable iff (reset)
		cheat_valid |-> (cheat_code == exp_cheat))
		else report_mismatch("cheat record fields misplaced");
	rom_req_timing: assert property (@(posedge clk_sys) disable iff (reset)
		rom_req == $past(cart_wr, 2))
		else report_mismatch("rom_req not 2 cycles after a cartridge write");
	rom_req_value: assert property (@(posedge clk_sys) disable iff (reset)
		rom_req |-> (rom_addr == expected_rom_addr($past(ioctl_addr, 2)))
			&& (rom_data == $past(ioctl_dout, 2)))
		else report_mismatch("rom_addr or rom_data wrong");
	wait_rise: assert property (@(posedge clk_sys) disable iff (reset)
		rom_req |-> ioctl_wait)
		else report_mismatch("ioctl_wait low with a request");
	wait_hold: assert property (@(posedge clk_sys) disable iff (reset)
		($past(ioctl_wait) && !$past(rom_ack)) |-> ioctl_wait)
		else report_mismatch("ioctl_wait fell before rom_ack");
	wait_fall: assert property (@(posedge clk_sys) disable iff (reset)
		($past(rom_ack) && !rom_req) |-> !ioctl_wait)
		else report_mismatch("ioctl_wait still high the cycle after rom_ack");
	wait_idle: assert property (@(posedge clk_sys) disable iff (reset)
		(!$past(ioctl_wait) && !rom_req) |-> !ioctl_wait)
		else report_mismatch("ioctl_wait rose without a request");
	cart_start_facts: assert property (@(posedge clk_sys) disable iff (reset)
		$past(cart_rise, 2) |-> cart_loaded && (cart_type == ioctl_index[7:6])
			&& !flash_1m && !sram_quirk && !memory_remap_quirk)
		else report_mismatch("cartridge facts not reset at start");
	cart_end_facts: assert property (@(posedge clk_sys) disable iff (reset)
		$past(cart_fall, 2) |-> cart_loaded && (cart_type == ioctl_index[7:6])
			&& (flash_1m == exp_flash) && (sram_quirk == exp_sram)
			&& (memory_remap_quirk == exp_remap) && (max_pak_addr == exp_max))
		else report_mismatch("cartridge facts wrong after download");

	// ==========================================================
	// Host side driven on the falling edge
	// ==========================================================
	task automatic host_write(input host_addr_t addr, input host_word_t data);
		ioctl_addr = addr;
		ioctl_dout = data;
		ioctl_wr   = 1'b1;               // One-cycle strobe
		@(negedge clk_sys);
		ioctl_wr   = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic begin_download(input host_index_t index);
		ioctl_index    = index;
		ioctl_download = 1'b1;
		@(negedge clk_sys);
	endtask

	task automatic end_download();
		ioctl_download = 1'b0;
		repeat (4) @(negedge clk_sys);   // End checks land in here
	endtask

	task automatic load_bios();
		host_addr_t base;
		host_word_t low;
		host_word_t high;
		begin_download(`CL_INDEX_BIOS);
		for (int p = 0; p < BIOS_PAIRS; p++) begin
			base       = host_addr_t'($urandom);
			base[1:0]  = 2'b00;           // 32-bit aligned pair
			low        = host_word_t'($urandom);
			high       = host_word_t'($urandom);
			host_write(base, low);
			exp_bios_data = {high, low};
			exp_bios_addr = base[13:2];
			host_write(base | 27'd2, high);
		end
		end_download();
	endtask

	task automatic load_cheats();
		host_word_t words [0:7];
		begin_download(`CL_INDEX_CHEAT);
		for (int r = 0; r < CHEAT_RECS; r++) begin
			for (int w = 0; w < 8; w++) begin
				words[w] = host_word_t'($urandom);
				exp_cheat[cheat_bit(w) +: 16] = words[w];
			end
			for (int w = 0; w < 8; w++)
				host_write(host_addr_t'(16 * r + 2 * w), words[w]);
			repeat (2) @(negedge clk_sys);   // Let the record check pass
		end
		end_download();
	endtask

	// tag_at below zero leaves the flash tag out
	task automatic load_cart(input host_index_t index, input int words, input cart_id_t title,
			input int tag_at, input logic sram, input logic remap);
		for (int a = 0; a < 2 * words; a++)
			image[a] = 8'($urandom);
		for (int i = 0; i < `CL_ID_BYTES; i++)
			image[HEADER_BYTE + i] = title[95 - 8 * i -: 8];   // First char at lowest byte
		if (tag_at >= 0) begin
			for (int i = 0; i < 9; i++)
				image[tag_at + i] = FLASH_TAG[71 - 8 * i -: 8];
		end
		exp_flash = (tag_at >= 0);
		exp_sram  = sram;
		exp_remap = remap;
		exp_max   = pak_addr_t'((2 * words - 2) / 4);   // Last byte address in 32-bit units

		begin_download(index);
		for (int a = 0; a < 2 * words; a += 2) begin
			host_write(host_addr_t'(a), {image[a + 1], image[a]});
			while (!ioctl_wait)
				@(negedge clk_sys);
			while (ioctl_wait)
				@(negedge clk_sys);      // Hold next word until the ack
		end
		end_download();
	endtask

	// ==========================================================
	// Memory model with a random ack delay
	// ==========================================================
	initial begin
		int delay;
		rom_ack = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (rom_req) begin
				delay = int'($urandom % 6);
				repeat (delay) @(negedge clk_sys);
				rom_ack = 1'b1;
				@(negedge clk_sys);
				rom_ack = 1'b0;
			end
		end
	end

	// Watchdog
	initial begin
		#(TIMEOUT_NS);
		abort_run($sformatf("Watchdog expired after %0d ns, the download stalled", TIMEOUT_NS));
	end

	// ==========================================================
	// Test sequence
	// ==========================================================
	initial begin
		void'($urandom(90387));
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		ioctl_wr       = 1'b0;
		@(negedge clk_sys);
		while (reset)
			@(negedge clk_sys);
		@(negedge clk_sys);

		load_bios();
		load_cheats();
		load_cart(8'h01, 96, "TESTCART0001", 40, 1'b1, 1'b0);    // Tag ends on a low byte
		load_cart(8'h45, 100, "TESTCART0002", -1, 1'b1, 1'b1);
		load_cart(8'h82, 90, "TESTCART0003", 81, 1'b0, 1'b1);    // Tag ends on a high byte
		load_cart(8'hC3, 94, "NOTLISTED123", -1, 1'b0, 1'b0);    // Not in the table

		repeat (4) @(negedge clk_sys);
		$display("test passed");
		$finish;
	end

endmodule

// File: cart_loader.f
+incdir+include
logic/cart_loader_pkg.sv
logic/download_if.sv
logic/download_decoder.sv
logic/bios_word_packer.sv
logic/cheat_code_assembler.sv
logic/cart_header_scan.sv
logic/rom_write_port.sv
logic/cart_loader.sv
bench/tb_clock_gen.sv
bench/cart_loader_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the cart_loader testbench with Verilator, run it, and decide on the log.
# Exit status is 0 only when the simulation log holds the pass line.

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert \
	--timescale 1ns/1ps \
	--top-module cart_loader_tb \
	-f cart_loader.f \
	-Mdir obj_dir \
	-o cart_loader_sim \
	> "$build_log" 2>&1
status=$?
if [ "$status" -ne 0 ]; then
	cat "$build_log"
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/cart_loader_sim > "$sim_log" 2>&1
status=$?
cat "$sim_log"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "test passed" "$sim_log"; then
	echo "Result: PASS"
	exit 0
fi
echo "Result: FAIL"
exit 1
